// File: flist.f
+incdir+sim
verilog/dcache_pkg.sv
verilog/bank_port_if.sv
verilog/dcache_bank.sv
verilog/banked_data_array.sv
verilog/lsu_port.sv
verilog/line_mover.sv
verilog/dcache_subsys_top.sv
sim/tb_dcache_subsys.sv

// File: sim/tb_dcache_tasks.svh
`ifndef TB_DCACHE_TASKS_SVH
`define TB_DCACHE_TASKS_SVH

task automatic check_eq(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
    if (actual !== expected) begin
        $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1, "value mismatch on %s", name);
    end
endtask

task automatic timeout_fail(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
endtask

// called and returns on a falling edge
task automatic core_access(input logic we, input logic [ADDR_W-1:0] addr,
                           input access_size_e size, input logic uns,
                           input logic [31:0] wdata);
    int          waited;
    logic [31:0] expected;
    waited            = 0;
    expected          = '0;
    core_req_valid    = 1'b1;
    core_req_we       = we;
    core_req_addr     = addr;
    core_req_size     = size;
    core_req_unsigned = uns;
    core_req_wdata    = wdata;
    #1;
    while (!core_req_ready) begin
        @(negedge clk);
        #1;
        waited++;
        if (waited > TIMEOUT) begin
            timeout_fail("core request never accepted");
        end
    end
    if (we) begin
        model_store(addr, size, wdata);
    end else begin
        expected = model_load(addr, size, uns);
    end
    @(negedge clk);
    core_req_valid = 1'b0;
    check_eq("core_rsp_valid", {31'd0, !we}, {31'd0, core_rsp_valid});
    if (!we) begin
        check_eq("core_rsp_rdata", expected, core_rsp_rdata);
    end
endtask

task automatic start_cmd(input logic writeback, input logic [LINE_W-1:0] line);
    int waited;
    waited           = 0;
    mc_cmd_valid     = 1'b1;
    mc_cmd_writeback = writeback;
    mc_cmd_line      = line;
    #1;
    while (!mc_cmd_ready) begin
        @(negedge clk);
        #1;
        waited++;
        if (waited > TIMEOUT) begin
            timeout_fail("line mover never took the command");
        end
    end
    @(negedge clk);
    mc_cmd_valid = 1'b0;
endtask

task automatic wait_done();
    int waited;
    waited = 0;
    while (!mc_done) begin
        @(negedge clk);
        waited++;
        if (waited > TIMEOUT) begin
            timeout_fail("mc_done never pulsed");
        end
    end
    // single cycle pulse
    @(negedge clk);
    check_eq("mc_done", 32'd0, {31'd0, mc_done});
endtask

`endif

// File: sim/tb_dcache_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_subsys
    import dcache_pkg::*;
();

    localparam int NUM_BANKS  = 2;
    localparam int LINE_WORDS = 4;
    localparam int NUM_LINES  = 16;
    localparam int ADDR_W     = $clog2(NUM_LINES * LINE_WORDS) + 2;
    localparam int LINE_W     = $clog2(NUM_LINES);
    localparam int TIMEOUT    = 200;

    logic              clk;
    logic              rst_n;
    logic              core_req_valid;
    logic              core_req_ready;
    logic              core_req_we;
    logic [ADDR_W-1:0] core_req_addr;
    access_size_e      core_req_size;
    logic              core_req_unsigned;
    logic [31:0]       core_req_wdata;
    logic              core_rsp_valid;
    logic [31:0]       core_rsp_rdata;
    logic              mc_cmd_valid;
    logic              mc_cmd_ready;
    logic              mc_cmd_writeback;
    logic [LINE_W-1:0] mc_cmd_line;
    logic              mc_done;
    logic              fill_valid;
    logic              fill_ready;
    logic [31:0]       fill_data;
    logic              wb_valid;
    logic              wb_ready;
    logic [31:0]       wb_data;

    integer            seed;
    // byte-wide image of the whole data array
    logic [7:0]        ref_mem [1 << ADDR_W];

    dcache_subsys_top #(
        .NUM_BANKS (NUM_BANKS),
        .LINE_WORDS(LINE_WORDS),
        .NUM_LINES (NUM_LINES)
    ) dcache_subsys_top_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .core_req_valid   (core_req_valid),
        .core_req_ready   (core_req_ready),
        .core_req_we      (core_req_we),
        .core_req_addr    (core_req_addr),
        .core_req_size    (core_req_size),
        .core_req_unsigned(core_req_unsigned),
        .core_req_wdata   (core_req_wdata),
        .core_rsp_valid   (core_rsp_valid),
        .core_rsp_rdata   (core_rsp_rdata),
        .mc_cmd_valid     (mc_cmd_valid),
        .mc_cmd_ready     (mc_cmd_ready),
        .mc_cmd_writeback (mc_cmd_writeback),
        .mc_cmd_line      (mc_cmd_line),
        .mc_done          (mc_done),
        .fill_valid       (fill_valid),
        .fill_ready       (fill_ready),
        .fill_data        (fill_data),
        .wb_valid         (wb_valid),
        .wb_ready         (wb_ready),
        .wb_data          (wb_data)
    );

    always #20 clk = ~clk;

    // little endian lanes, unused low address bits dropped
    task automatic model_store(input logic [ADDR_W-1:0] addr, input access_size_e size,
                               input logic [31:0] wdata);
        case (size)
            size_byte: ref_mem[addr] = wdata[7:0];
            size_half: begin
                for (int i = 0; i < 2; i++) begin
                    ref_mem[{addr[ADDR_W-1:1], 1'b0} + i] = wdata[8*i +: 8];
                end
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[{addr[ADDR_W-1:2], 2'b00} + i] = wdata[8*i +: 8];
                end
            end
        endcase
    endtask

    function automatic logic [31:0] model_load(input logic [ADDR_W-1:0] addr,
                                               input access_size_e size, input logic uns);
        logic [ADDR_W-1:0] a;
        logic [31:0]       v;
        case (size)
            size_byte: begin
                v = {24'd0, ref_mem[addr]};
                if (!uns && v[7]) begin
                    v[31:8] = '1;
                end
            end
            size_half: begin
                a = {addr[ADDR_W-1:1], 1'b0};
                v = {16'd0, ref_mem[a + 1], ref_mem[a]};
                if (!uns && v[15]) begin
                    v[31:16] = '1;
                end
            end
            default: begin
                a = {addr[ADDR_W-1:2], 2'b00};
                v = {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
            end
        endcase
        return v;
    endfunction

    `include "tb_dcache_tasks.svh"

    task automatic verify_line(input logic [LINE_W-1:0] line);
        for (int i = 0; i < LINE_WORDS; i++) begin
            core_access(1'b0, (line * LINE_WORDS + i) * 4, size_word, 1'b0, 32'd0);
        end
    endtask

    // words with random gaps on fill_valid
    task automatic fill_line(input logic [LINE_W-1:0] line);
        int          taken;
        int          waited;
        logic [31:0] word;
        taken  = 0;
        waited = 0;
        start_cmd(1'b0, line);
        while (taken < LINE_WORDS) begin
            word       = $random(seed);
            fill_valid = ($random(seed) & 3) != 0;
            fill_data  = word;
            #1;
            if (fill_valid && fill_ready) begin
                model_store((line * LINE_WORDS + taken) * 4, size_word, word);
                taken++;
            end
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                timeout_fail("fill words not accepted");
            end
        end
        fill_valid = 1'b0;
        wait_done();
    endtask

    task automatic writeback_line(input logic [LINE_W-1:0] line);
        int count;
        int waited;
        count  = 0;
        waited = 0;
        start_cmd(1'b1, line);
        while (!mc_done) begin
            wb_ready = $random(seed);
            if (wb_valid && wb_ready) begin
                check_eq("wb_data", model_load((line * LINE_WORDS + count) * 4, size_word, 1'b0),
                         wb_data);
                count++;
            end
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                timeout_fail("writeback did not finish");
            end
        end
        wb_ready = 1'b0;
        check_eq("wb transfer count", LINE_WORDS, count);
        @(negedge clk);
        check_eq("mc_done", 32'd0, {31'd0, mc_done});
    endtask

    task automatic test_word();
        logic [ADDR_W-1:0] addrs [8];
        for (int i = 0; i < 8; i++) begin
            addrs[i]      = $random(seed);
            addrs[i][1:0] = 2'b00;
            core_access(1'b1, addrs[i], size_word, 1'b0, $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            core_access(1'b0, addrs[i], size_word, 1'b0, 32'd0);
        end
    endtask

    task automatic test_subword();
        logic [ADDR_W-1:0] base;
        logic [1:0]        off;
        repeat (4) begin
            base       = $random(seed);
            base[1:0]  = 2'b00;
            off        = $random(seed);
            core_access(1'b1, base, size_word, 1'b0, $random(seed));
            core_access(1'b1, base + off, size_byte, 1'b0, $random(seed));
            core_access(1'b1, base + (off ^ 2'd2), size_half, 1'b0, $random(seed));
            core_access(1'b0, base, size_word, 1'b0, 32'd0);
            for (int i = 0; i < 4; i++) begin
                core_access(1'b0, base + i, size_byte, 1'b0, 32'd0);
                core_access(1'b0, base + i, size_byte, 1'b1, 32'd0);
                // odd offsets hit the same half, unsigned
                core_access(1'b0, base + i, size_half, i[0], 32'd0);
            end
        end
    endtask

    task automatic test_back_to_back();
        logic [ADDR_W-1:0] base;
        logic [31:0]       expected;
        base      = $random(seed);
        base[2:0] = 3'b000;
        for (int i = 0; i < 8; i++) begin
            core_access(1'b1, base + 4 * i, size_word, 1'b0, $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            core_req_valid = 1'b1;
            core_req_we    = 1'b0;
            core_req_addr  = base + 4 * i;
            core_req_size  = size_word;
            expected       = model_load(base + 4 * i, size_word, 1'b0);
            #1;
            check_eq("core_req_ready", 32'd1, {31'd0, core_req_ready});
            @(negedge clk);
            check_eq("core_rsp_valid", 32'd1, {31'd0, core_rsp_valid});
            check_eq("core_rsp_rdata", expected, core_rsp_rdata);
        end
        core_req_valid = 1'b0;
    endtask

    task automatic core_traffic(input logic [LINE_W-1:0] line);
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < 12; i++) begin
            addr      = $random(seed);
            addr[1:0] = 2'b00;
            // stay off the line being filled
            if (addr[ADDR_W-1 -: LINE_W] == line) begin
                addr[ADDR_W-1] = ~addr[ADDR_W-1];
            end
            core_access(1'b1, addr, size_word, 1'b0, $random(seed));
            core_access(1'b0, addr, size_word, 1'b0, 32'd0);
        end
    endtask

    initial begin
        logic [LINE_W-1:0] line;
        seed              = 32'he931;
        clk               = 1'b0;
        rst_n             = 1'b0;
        core_req_valid    = 1'b0;
        core_req_we       = 1'b0;
        core_req_addr     = '0;
        core_req_size     = size_word;
        core_req_unsigned = 1'b0;
        core_req_wdata    = '0;
        mc_cmd_valid      = 1'b0;
        mc_cmd_writeback  = 1'b0;
        mc_cmd_line       = '0;
        fill_valid        = 1'b0;
        fill_data         = '0;
        wb_ready          = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_eq("mc_cmd_ready", 32'd1, {31'd0, mc_cmd_ready});
        check_eq("core_rsp_valid", 32'd0, {31'd0, core_rsp_valid});
        check_eq("fill_ready", 32'd0, {31'd0, fill_ready});
        check_eq("wb_valid", 32'd0, {31'd0, wb_valid});
        check_eq("mc_done", 32'd0, {31'd0, mc_done});

        test_word();
        test_subword();
        test_back_to_back();

        line = $random(seed);
        fill_line(line);
        verify_line(line);

        line = $random(seed);
        for (int i = 0; i < LINE_WORDS; i++) begin
            core_access(1'b1, (line * LINE_WORDS + i) * 4, size_word, 1'b0, $random(seed));
        end
        writeback_line(line);

        line = $random(seed);
        fork
            fill_line(line);
            core_traffic(line);
        join
        verify_line(line);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/bank_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bank_port_if
    import dcache_pkg::*;
#(
    parameter int NUM_BANKS   = 2,
    parameter int WORD_ADDR_W = 6
) ();

    localparam int BANK_W = $clog2(NUM_BANKS);

    logic                   req;
    logic                   gnt;
    logic                   we;
    logic [WORD_ADDR_W-1:0] waddr;
    logic [3:0]             wmask;
    data_word_u             wdata;
    logic                   rvalid;
    data_word_u             rdata;

    // word interleave, bank select in the low address bits
    logic [BANK_W-1:0]      bank;
    assign bank = waddr[BANK_W-1:0];

    modport requester (
        output req, we, waddr, wmask, wdata,
        input  gnt, rvalid, rdata
    );

    modport array (
        input  req, we, waddr, wmask, wdata, bank,
        output gnt, rvalid, rdata
    );

endinterface

`default_nettype wire

// File: verilog/banked_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module banked_data_array
    import dcache_pkg::*;
#(
    parameter int NUM_BANKS  = 2,
    parameter int LINE_WORDS = 4,
    parameter int NUM_LINES  = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    bank_port_if.array core,
    bank_port_if.array mover
);

    localparam int WORD_ADDR_W = $clog2(NUM_LINES * LINE_WORDS);
    localparam int BANK_W      = $clog2(NUM_BANKS);
    localparam int ROW_W       = WORD_ADDR_W - BANK_W;
    localparam int DEPTH       = (NUM_LINES * LINE_WORDS) / NUM_BANKS;

    logic [NUM_BANKS-1:0] core_sel;
    logic [NUM_BANKS-1:0] mover_sel;
    logic [NUM_BANKS-1:0] bank_en;
    logic [NUM_BANKS-1:0] bank_we;
    logic [ROW_W-1:0]     bank_row   [NUM_BANKS];
    logic [3:0]           bank_wmask [NUM_BANKS];
    data_word_u           bank_wdata [NUM_BANKS];
    data_word_u           bank_rdata [NUM_BANKS];

    logic [ROW_W-1:0]     core_row;
    logic [ROW_W-1:0]     mover_row;
    logic                 core_rd_q;
    logic                 mover_rd_q;
    logic [BANK_W-1:0]    core_bank_q;
    logic [BANK_W-1:0]    mover_bank_q;

    assign core_row  = core.waddr[WORD_ADDR_W-1:BANK_W];
    assign mover_row = mover.waddr[WORD_ADDR_W-1:BANK_W];

    // mover always wins, core only loses on a same-bank clash
    assign mover.gnt = mover.req;
    assign core.gnt  = core.req && !(mover.req && mover.bank == core.bank);

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign core_sel[b]  = core.req && core.bank == BANK_W'(b);
        assign mover_sel[b] = mover.req && mover.bank == BANK_W'(b);

        assign bank_en[b]    = core_sel[b] || mover_sel[b];
        assign bank_we[b]    = mover_sel[b] ? mover.we    : core.we;
        assign bank_row[b]   = mover_sel[b] ? mover_row   : core_row;
        assign bank_wmask[b] = mover_sel[b] ? mover.wmask : core.wmask;
        assign bank_wdata[b] = mover_sel[b] ? mover.wdata : core.wdata;

        dcache_bank #(
            .DEPTH(DEPTH)
        ) bank_i (
            .clk  (clk),
            .en   (bank_en[b]),
            .we   (bank_we[b]),
            .row  (bank_row[b]),
            .wmask(bank_wmask[b]),
            .wdata(bank_wdata[b]),
            .rdata(bank_rdata[b])
        );
    end

    // remember accepted reads for the return path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_rd_q  <= 1'b0;
            mover_rd_q <= 1'b0;
        end else begin
            core_rd_q  <= core.req && core.gnt && !core.we;
            mover_rd_q <= mover.req && mover.gnt && !mover.we;
        end
    end

    always_ff @(posedge clk) begin
        core_bank_q  <= core.bank;
        mover_bank_q <= mover.bank;
    end

    assign core.rvalid  = core_rd_q;
    assign core.rdata   = bank_rdata[core_bank_q];
    assign mover.rvalid = mover_rd_q;
    assign mover.rdata  = bank_rdata[mover_bank_q];

endmodule

`default_nettype wire

// File: verilog/dcache_bank.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_bank
    import dcache_pkg::*;
#(
    parameter int DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] row,
    input  logic [3:0]               wmask,
    input  data_word_u               wdata,
    output data_word_u               rdata
);

    data_word_u mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                // byte lanes written independently
                for (int b = 0; b < 4; b++) begin
                    if (wmask[b]) begin
                        mem[row].bytes[b] <= wdata.bytes[b];
                    end
                end
            end else begin
                rdata <= mem[row];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // one data word, whole or split into byte lanes
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } data_word_u;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_e;

    // line mover command direction
    typedef enum logic {
        dir_fill      = 1'b0,
        dir_writeback = 1'b1
    } xfer_dir_e;

endpackage

`default_nettype wire

// File: verilog/dcache_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_subsys_top
    import dcache_pkg::*;
#(
    parameter int NUM_BANKS  = 2,
    parameter int LINE_WORDS = 4,
    parameter int NUM_LINES  = 16
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   core_req_valid,
    output logic                                   core_req_ready,
    input  logic                                   core_req_we,
    input  logic [$clog2(NUM_LINES*LINE_WORDS)+1:0] core_req_addr,
    input  access_size_e                           core_req_size,
    input  logic                                   core_req_unsigned,
    input  logic [31:0]                            core_req_wdata,
    output logic                                   core_rsp_valid,
    output logic [31:0]                            core_rsp_rdata,
    input  logic                                   mc_cmd_valid,
    output logic                                   mc_cmd_ready,
    input  logic                                   mc_cmd_writeback,
    input  logic [$clog2(NUM_LINES)-1:0]           mc_cmd_line,
    output logic                                   mc_done,
    input  logic                                   fill_valid,
    output logic                                   fill_ready,
    input  logic [31:0]                            fill_data,
    output logic                                   wb_valid,
    input  logic                                   wb_ready,
    output logic [31:0]                            wb_data
);

    localparam int WORD_ADDR_W = $clog2(NUM_LINES * LINE_WORDS);

    bank_port_if #(
        .NUM_BANKS  (NUM_BANKS),
        .WORD_ADDR_W(WORD_ADDR_W)
    ) core_port ();

    bank_port_if #(
        .NUM_BANKS  (NUM_BANKS),
        .WORD_ADDR_W(WORD_ADDR_W)
    ) mover_port ();

    lsu_port #(
        .NUM_BANKS (NUM_BANKS),
        .LINE_WORDS(LINE_WORDS),
        .NUM_LINES (NUM_LINES)
    ) lsu_port_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (core_req_valid),
        .req_ready   (core_req_ready),
        .req_we      (core_req_we),
        .req_addr    (core_req_addr),
        .req_size    (core_req_size),
        .req_unsigned(core_req_unsigned),
        .req_wdata   (core_req_wdata),
        .rsp_valid   (core_rsp_valid),
        .rsp_rdata   (core_rsp_rdata),
        .mem         (core_port.requester)
    );

    line_mover #(
        .NUM_BANKS (NUM_BANKS),
        .LINE_WORDS(LINE_WORDS),
        .NUM_LINES (NUM_LINES)
    ) line_mover_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (mc_cmd_valid),
        .cmd_ready    (mc_cmd_ready),
        .cmd_writeback(mc_cmd_writeback),
        .cmd_line     (mc_cmd_line),
        .done         (mc_done),
        .fill_valid   (fill_valid),
        .fill_ready   (fill_ready),
        .fill_data    (fill_data),
        .wb_valid     (wb_valid),
        .wb_ready     (wb_ready),
        .wb_data      (wb_data),
        .mem          (mover_port.requester)
    );

    banked_data_array #(
        .NUM_BANKS (NUM_BANKS),
        .LINE_WORDS(LINE_WORDS),
        .NUM_LINES (NUM_LINES)
    ) banked_data_array_i (
        .clk  (clk),
        .rst_n(rst_n),
        .core (core_port.array),
        .mover(mover_port.array)
    );

endmodule

`default_nettype wire

// File: verilog/line_mover.sv
`timescale 1ns/1ps
`default_nettype none

module line_mover
    import dcache_pkg::*;
#(
    parameter int NUM_BANKS  = 2,
    parameter int LINE_WORDS = 4,
    parameter int NUM_LINES  = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cmd_valid,
    output logic                         cmd_ready,
    input  logic                         cmd_writeback,
    input  logic [$clog2(NUM_LINES)-1:0] cmd_line,
    output logic                         done,
    input  logic                         fill_valid,
    output logic                         fill_ready,
    input  logic [31:0]                  fill_data,
    output logic                         wb_valid,
    input  logic                         wb_ready,
    output logic [31:0]                  wb_data,
    bank_port_if.requester               mem
);

    localparam int LINE_W      = $clog2(NUM_LINES);
    localparam int OFF_W       = $clog2(LINE_WORDS);
    localparam int WORD_ADDR_W = $clog2(NUM_BANKS) + $clog2((NUM_LINES * LINE_WORDS) / NUM_BANKS);

    typedef enum logic [2:0] {
        st_idle,
        st_filling,
        st_wb_read,
        st_wb_wait,
        st_wb_hold
    } state_e;

    state_e            state_q;
    logic [OFF_W-1:0]  cnt_q;
    logic [LINE_W-1:0] line_q;
    logic [31:0]       hold_q;
    logic              done_q;
    xfer_dir_e         cmd_dir;
    logic              last_word;
    logic              fill_take;
    logic              wb_take;

    assign cmd_dir   = cmd_writeback ? dir_writeback : dir_fill;
    assign last_word = cnt_q == OFF_W'(LINE_WORDS - 1);
    assign cmd_ready = state_q == st_idle;

    assign mem.req        = (state_q == st_filling && fill_valid) || state_q == st_wb_read;
    assign mem.we         = state_q == st_filling;
    assign mem.waddr      = WORD_ADDR_W'({line_q, cnt_q});
    assign mem.wmask      = 4'b1111;
    assign mem.wdata.word = fill_data;

    // stall the fill stream only while our own write waits for grant
    assign fill_ready = state_q == st_filling && !(mem.req && !mem.gnt);
    assign fill_take  = fill_valid && fill_ready;

    assign wb_valid = state_q == st_wb_hold;
    assign wb_data  = hold_q;
    assign wb_take  = wb_valid && wb_ready;
    assign done     = done_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                st_idle: begin
                    cnt_q <= '0;
                    if (cmd_valid) begin
                        state_q <= (cmd_dir == dir_writeback) ? st_wb_read : st_filling;
                    end
                end
                st_filling: begin
                    if (fill_take) begin
                        cnt_q <= cnt_q + OFF_W'(1);
                        if (last_word) begin
                            state_q <= st_idle;
                            done_q  <= 1'b1;
                        end
                    end
                end
                st_wb_read: begin
                    if (mem.gnt) begin
                        state_q <= st_wb_wait;
                    end
                end
                st_wb_wait: begin
                    if (mem.rvalid) begin
                        state_q <= st_wb_hold;
                    end
                end
                st_wb_hold: begin
                    if (wb_take) begin
                        cnt_q   <= cnt_q + OFF_W'(1);
                        state_q <= last_word ? st_idle : st_wb_read;
                        done_q  <= last_word;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && cmd_valid) begin
            line_q <= cmd_line;
        end
        // writeback word held until the stream takes it
        if (state_q == st_wb_wait && mem.rvalid) begin
            hold_q <= mem.rdata.word;
        end
    end

endmodule

`default_nettype wire

// File: verilog/lsu_port.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_port
    import dcache_pkg::*;
#(
    parameter int NUM_BANKS  = 2,
    parameter int LINE_WORDS = 4,
    parameter int NUM_LINES  = 16
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   req_valid,
    output logic                                   req_ready,
    input  logic                                   req_we,
    input  logic [$clog2(NUM_LINES*LINE_WORDS)+1:0] req_addr,
    input  access_size_e                           req_size,
    input  logic                                   req_unsigned,
    input  logic [31:0]                            req_wdata,
    output logic                                   rsp_valid,
    output logic [31:0]                            rsp_rdata,
    bank_port_if.requester                         mem
);

    // word address is the bank row above the bank select
    localparam int BANK_W      = $clog2(NUM_BANKS);
    localparam int WORD_ADDR_W = BANK_W + $clog2((NUM_LINES * LINE_WORDS) / NUM_BANKS);
    localparam int BYTE_ADDR_W = WORD_ADDR_W + 2;

    logic [1:0]   offset;
    logic [3:0]   st_mask;
    data_word_u   st_word;
    logic [1:0]   ld_off;
    access_size_e ld_size;
    logic         ld_unsigned;
    data_word_u   ld_word;
    logic [7:0]   ld_byte;
    logic [15:0]  ld_half;

    assign offset    = req_addr[1:0];
    assign req_ready = mem.gnt;

    assign mem.req   = req_valid;
    assign mem.we    = req_we;
    assign mem.waddr = req_addr[BYTE_ADDR_W-1:2];
    assign mem.wmask = st_mask;
    assign mem.wdata = st_word;

    always_comb begin
        case (req_size)
            size_byte: st_mask = 4'b0001 << offset;
            size_half: st_mask = offset[1] ? 4'b1100 : 4'b0011;
            default:   st_mask = 4'b1111;
        endcase
        // store data copied onto every lane, mask picks the live ones
        for (int i = 0; i < 4; i++) begin
            case (req_size)
                size_byte: st_word.bytes[i] = req_wdata[7:0];
                size_half: st_word.bytes[i] = req_wdata[8*(i%2) +: 8];
                default:   st_word.bytes[i] = req_wdata[8*i +: 8];
            endcase
        end
    end

    // load format for the response one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_off      <= 2'd0;
            ld_size     <= size_word;
            ld_unsigned <= 1'b0;
        end else if (req_valid && mem.gnt && !req_we) begin
            ld_off      <= offset;
            ld_size     <= req_size;
            ld_unsigned <= req_unsigned;
        end
    end

    assign ld_word = mem.rdata;
    assign ld_byte = ld_word.bytes[ld_off];
    assign ld_half = {ld_word.bytes[{ld_off[1], 1'b1}], ld_word.bytes[{ld_off[1], 1'b0}]};

    always_comb begin
        case (ld_size)
            size_byte: rsp_rdata = {{24{ld_byte[7] && !ld_unsigned}}, ld_byte};
            size_half: rsp_rdata = {{16{ld_half[15] && !ld_unsigned}}, ld_half};
            default:   rsp_rdata = ld_word.word;
        endcase
    end

    assign rsp_valid = mem.rvalid;

endmodule

`default_nettype wire
